//--- src/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int XLEN_INST = 32;
    localparam int PC_W = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W = 20;

    localparam logic [PC_W-1:0] RESET_PC = '0;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // major opcodes
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP32    = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // funct12 of the privileged SYSTEM words
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    localparam logic [1:0] DISP_INT     = 2'd0;
    localparam logic [1:0] DISP_MEM     = 2'd1;
    localparam logic [1:0] DISP_UNKNOWN = 2'd2;

    localparam logic [1:0] IQ_ALU = 2'd0;
    localparam logic [1:0] IQ_BRU = 2'd1;
    localparam logic [1:0] IQ_MDU = 2'd2;
    localparam logic [1:0] IQ_SCU = 2'd3;

    // sixteen live ALU ops leave no spare code for none
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_ADDW, ALU_SUBW,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW,
        ALU_SRLW, ALU_SRAW, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BRU_NONE, BRU_AUIPC, BRU_JAL, BRU_JALR, BRU_BEQ,
        BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU
    } bru_op_e;

    typedef enum logic [3:0] {
        MDU_NONE, MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU,
        MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU, MDU_MULW,
        MDU_DIVW, MDU_DIVUW, MDU_REMW, MDU_REMUW
    } mdu_op_e;

    typedef enum logic [3:0] {
        SCU_NONE, SCU_MRET, SCU_ECALL, SCU_EBREAK, SCU_CSRRW,
        SCU_CSRRS, SCU_CSRRC, SCU_CSRRWI, SCU_CSRRSI, SCU_CSRRCI
    } scu_op_e;

    // member to read is picked by the issue queue id
    typedef union packed {
        alu_op_e alu;
        bru_op_e bru;
        mdu_op_e mdu;
        scu_op_e scu;
    } micro_op_u;

endpackage

`default_nettype wire

//--- src/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch import decode_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic [PC_W-1:0]        o_wb_adr,
    input  logic                   i_wb_ack,
    input  logic [XLEN_INST-1:0]   i_wb_dat,
    output logic                   o_push,
    output logic [PC_W-1:0]        o_push_pc,
    output logic [XLEN_INST-1:0]   o_push_inst,
    input  logic [QUEUE_CNT_W-1:0] i_free_slots
);

    logic [PC_W-1:0] fetch_pc;
    logic            bus_busy;

    // a free slot at the start leaves room for the word on ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus_busy <= 1'b0;
            fetch_pc <= RESET_PC;
        end else if (bus_busy) begin
            if (i_wb_ack) begin
                bus_busy <= 1'b0;
                fetch_pc <= fetch_pc + PC_W'(4);
            end
        end else if (i_free_slots != '0) begin
            bus_busy <= 1'b1;
        end
    end

    // classic read, stb follows cyc
    assign o_wb_cyc = bus_busy;
    assign o_wb_stb = bus_busy;
    assign o_wb_adr = fetch_pc;

    assign o_push = bus_busy && i_wb_ack;
    assign o_push_pc = fetch_pc;
    assign o_push_inst = i_wb_dat;

endmodule

`default_nettype wire

//--- src/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue import decode_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_push,
    input  logic [PC_W-1:0]        i_push_pc,
    input  logic [XLEN_INST-1:0]   i_push_inst,
    output logic [QUEUE_CNT_W-1:0] o_free_slots,
    output logic                   o_not_empty,
    output logic [PC_W-1:0]        o_head_pc,
    output logic [XLEN_INST-1:0]   o_head_inst,
    input  logic                   i_pop
);

    logic [PC_W-1:0]        pc_mem   [QUEUE_DEPTH];
    logic [XLEN_INST-1:0]   inst_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            pc_mem[wr_ptr] <= i_push_pc;
            inst_mem[wr_ptr] <= i_push_inst;
        end
    end

    assign o_free_slots = QUEUE_CNT_W'(QUEUE_DEPTH) - count;
    assign o_not_empty = (count != '0);
    assign o_head_pc = pc_mem[rd_ptr];
    assign o_head_inst = inst_mem[rd_ptr];

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_not_empty,
    input  logic [PC_W-1:0]      i_head_pc,
    input  logic [XLEN_INST-1:0] i_head_inst,
    output logic                 o_pop,
    output logic                 o_dec_valid,
    input  logic                 i_dec_ready,
    output logic [PC_W-1:0]      o_pc,
    output logic                 o_unknown,
    output logic [1:0]           o_disp_q,
    output logic [1:0]           o_issue_q,
    output micro_op_u            o_micro_op,
    output logic                 o_rd_wen,
    output logic [REG_IDX_W-1:0] o_rd_idx,
    output logic [REG_IDX_W-1:0] o_rs1_idx,
    output logic [REG_IDX_W-1:0] o_rs2_idx,
    output logic [IMM_W-1:0]     o_imm,
    output logic                 o_use_imm,
    output logic                 o_is_mv,
    output logic                 o_serialize,
    output logic                 o_is_store
);

    wire [XLEN_INST-1:0] inst = i_head_inst;
    wire [6:0] opc = inst[6:0];
    wire [2:0] f3 = inst[14:12];
    wire [6:0] f7 = inst[31:25];
    wire [11:0] f12 = inst[31:20];
    wire [REG_IDX_W-1:0] rd = inst[11:7];
    wire [REG_IDX_W-1:0] rs1 = inst[19:15];
    wire [REG_IDX_W-1:0] rs2 = inst[24:20];

    wire is_shift = (f3[1:0] == 2'b01);
    wire alt_ok = (f7 == F7_BASE) || ((f7 == F7_ALT) && (f3 == 3'd0 || f3 == 3'd5));
    // RV64 shamt is 6 bits wide and eats funct7 bit 0
    wire shamt6_ok = (f7[6:1] == F7_BASE[6:1]) || ((f7[6:1] == F7_ALT[6:1]) && f3[2]);
    wire shamt5_ok = (f7 == F7_BASE) || ((f7 == F7_ALT) && f3[2]);

    wire is_lui = (opc == OPC_LUI);
    wire is_auipc = (opc == OPC_AUIPC);
    wire is_jal = (opc == OPC_JAL);
    wire is_jalr = (opc == OPC_JALR) && (f3 == 3'd0);
    wire is_branch = (opc == OPC_BRANCH) && (f3[2:1] != 2'b01);
    wire is_load = (opc == OPC_LOAD) && (f3 != 3'd7);
    wire is_store = (opc == OPC_STORE) && !f3[2];
    wire is_op = (opc == OPC_OP) && alt_ok;
    wire is_op32 = (opc == OPC_OP32) && alt_ok && (f3 == 3'd0 || is_shift);
    wire is_opimm = (opc == OPC_OPIMM) && (!is_shift || shamt6_ok);
    wire is_opimm32 = (opc == OPC_OPIMM32) && (f3 == 3'd0 || (is_shift && shamt5_ok));
    wire is_muldiv = (f7 == F7_MULDIV)
                  && ((opc == OPC_OP) || ((opc == OPC_OP32) && (f3 == 3'd0 || f3[2])));
    // privileged words need rd and rs1 zero
    wire sys_base = (opc == OPC_SYSTEM) && (f3 == 3'd0) && (rs1 == '0) && (rd == '0);
    wire is_ecall = sys_base && (f12 == F12_ECALL);
    wire is_ebreak = sys_base && (f12 == F12_EBREAK);
    wire is_mret = sys_base && (f12 == F12_MRET);
    wire is_csr = (opc == OPC_SYSTEM) && (f3[1:0] != 2'b00);

    wire int_math = is_op || is_op32;
    wire imm_math = is_opimm || is_opimm32;
    wire is_word = (opc == OPC_OP32) || (opc == OPC_OPIMM32);
    wire is_alu = int_math || imm_math || is_lui;
    wire is_bru = is_branch || is_jal || is_jalr || is_auipc;
    wire is_mem = is_load || is_store;
    wire is_scu = is_csr || is_ecall || is_ebreak || is_mret;
    wire unknown = !(is_alu || is_bru || is_mem || is_muldiv || is_scu);

    wire [IMM_W-1:0] imm_i = {{8{inst[31]}}, f12};
    wire [IMM_W-1:0] imm_s = {{8{inst[31]}}, f7, rd};
    wire [IMM_W-1:0] imm_b = {{8{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    // J offset held in half-words so bit 20 survives
    wire [IMM_W-1:0] imm_j = {inst[31], inst[19:12], inst[20], inst[30:21]};
    wire [IMM_W-1:0] imm_u = inst[31:12];
    wire [IMM_W-1:0] imm_csr = {3'd0, f12, rs1};
    wire [IMM_W-1:0] imm_sh = {14'd0, inst[25:20]};

    wire [IMM_W-1:0] imm =
        (is_lui || is_auipc)   ? imm_u :
        is_branch              ? imm_b :
        is_store               ? imm_s :
        (is_load || is_jalr)   ? imm_i :
        (imm_math && is_shift) ? imm_sh :
        imm_math               ? imm_i :
        is_jal                 ? imm_j :
        is_csr                 ? imm_csr :
        '0;

    // addi rd,rs,0 and add rd,rs,x0
    wire is_mv = (is_opimm && f3 == 3'd0 && f12 == '0)
              || (is_op && f3 == 3'd0 && f7 == F7_BASE && rs2 == '0);
    wire rd_wen = (rd != '0)
               && (is_alu || is_jal || is_jalr || is_auipc || is_load || is_muldiv || is_csr);
    // CSR immediate forms carry zimm in the rs1 field
    wire use_rs1 = is_jalr || is_branch || is_mem || int_math || imm_math || is_muldiv
                || (is_csr && !f3[2]);
    wire use_rs2 = is_branch || is_store || int_math || is_muldiv;
    wire use_imm = (imm_math || is_bru || is_lui || is_csr) && !is_mv;
    wire [1:0] disp_q = unknown ? DISP_UNKNOWN : is_mem ? DISP_MEM : DISP_INT;

    alu_op_e   alu_op;
    bru_op_e   bru_op;
    mdu_op_e   mdu_op;
    scu_op_e   scu_op;
    micro_op_u micro_op;
    logic [1:0] issue_q;

    always_comb begin
        case (f3)
            3'd0: alu_op = (int_math && inst[30]) ? (is_word ? ALU_SUBW : ALU_SUB)
                                                  : (is_word ? ALU_ADDW : ALU_ADD);
            3'd1: alu_op = is_word ? ALU_SLLW : ALU_SLL;
            3'd2: alu_op = ALU_SLT;
            3'd3: alu_op = ALU_SLTU;
            3'd4: alu_op = ALU_XOR;
            3'd5: alu_op = inst[30] ? (is_word ? ALU_SRAW : ALU_SRA)
                                    : (is_word ? ALU_SRLW : ALU_SRL);
            3'd6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (is_lui) begin
            alu_op = ALU_LUI;
        end
    end

    always_comb begin
        case (f3)
            3'd0: bru_op = BRU_BEQ;
            3'd1: bru_op = BRU_BNE;
            3'd4: bru_op = BRU_BLT;
            3'd5: bru_op = BRU_BGE;
            3'd6: bru_op = BRU_BLTU;
            default: bru_op = BRU_BGEU;
        endcase
        if (!is_branch) begin
            bru_op = is_auipc ? BRU_AUIPC : is_jal ? BRU_JAL : is_jalr ? BRU_JALR : BRU_NONE;
        end
    end

    always_comb begin
        case (f3)
            3'd0: mdu_op = is_word ? MDU_MULW : MDU_MUL;
            3'd1: mdu_op = MDU_MULH;
            3'd2: mdu_op = MDU_MULHSU;
            3'd3: mdu_op = MDU_MULHU;
            3'd4: mdu_op = is_word ? MDU_DIVW : MDU_DIV;
            3'd5: mdu_op = is_word ? MDU_DIVUW : MDU_DIVU;
            3'd6: mdu_op = is_word ? MDU_REMW : MDU_REM;
            default: mdu_op = is_word ? MDU_REMUW : MDU_REMU;
        endcase
    end

    always_comb begin
        case (f3)
            3'd1: scu_op = SCU_CSRRW;
            3'd2: scu_op = SCU_CSRRS;
            3'd3: scu_op = SCU_CSRRC;
            3'd5: scu_op = SCU_CSRRWI;
            3'd6: scu_op = SCU_CSRRSI;
            3'd7: scu_op = SCU_CSRRCI;
            default: scu_op = is_mret  ? SCU_MRET :
                              is_ecall ? SCU_ECALL :
                              is_ebreak ? SCU_EBREAK : SCU_NONE;
        endcase
    end

    // loads and stores keep code 0 (ALU_ADD) for the address sum
    always_comb begin
        micro_op = '0;
        issue_q = IQ_ALU;
        if (is_bru) begin
            micro_op.bru = bru_op;
            issue_q = IQ_BRU;
        end else if (is_muldiv) begin
            micro_op.mdu = mdu_op;
            issue_q = IQ_MDU;
        end else if (is_scu) begin
            micro_op.scu = scu_op;
            issue_q = IQ_SCU;
        end else if (is_alu) begin
            micro_op.alu = alu_op;
        end
    end

    assign o_pop = i_not_empty && (!o_dec_valid || i_dec_ready);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
        end else if (o_pop) begin
            o_dec_valid <= 1'b1;
        end else if (i_dec_ready) begin
            o_dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_pc <= i_head_pc;
            o_unknown <= unknown;
            o_disp_q <= disp_q;
            o_issue_q <= issue_q;
            o_micro_op <= micro_op;
            o_rd_wen <= rd_wen;
            o_rd_idx <= rd_wen ? rd : '0;
            o_rs1_idx <= use_rs1 ? rs1 : '0;
            o_rs2_idx <= use_rs2 ? rs2 : '0;
            o_imm <= imm;
            o_use_imm <= use_imm;
            o_is_mv <= is_mv;
            o_serialize <= is_scu;
            o_is_store <= is_store;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top import decode_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic [PC_W-1:0]      o_wb_adr,
    input  logic                 i_wb_ack,
    input  logic [XLEN_INST-1:0] i_wb_dat,
    input  logic                 i_dec_ready,
    output logic                 o_dec_valid,
    output logic [PC_W-1:0]      o_pc,
    output logic                 o_unknown,
    output logic [1:0]           o_disp_q,
    output logic [1:0]           o_issue_q,
    output micro_op_u            o_micro_op,
    output logic                 o_rd_wen,
    output logic [REG_IDX_W-1:0] o_rd_idx,
    output logic [REG_IDX_W-1:0] o_rs1_idx,
    output logic [REG_IDX_W-1:0] o_rs2_idx,
    output logic [IMM_W-1:0]     o_imm,
    output logic                 o_use_imm,
    output logic                 o_is_mv,
    output logic                 o_serialize,
    output logic                 o_is_store
);

    logic                   push;
    logic [PC_W-1:0]        push_pc;
    logic [XLEN_INST-1:0]   push_inst;
    logic [QUEUE_CNT_W-1:0] free_slots;
    logic                   not_empty;
    logic [PC_W-1:0]        head_pc;
    logic [XLEN_INST-1:0]   head_inst;
    logic                   pop;

    // read-only master, WE stays low on the bus
    inst_fetch inst_fetch_i (
        .*,
        .o_push       (push),
        .o_push_pc    (push_pc),
        .o_push_inst  (push_inst),
        .i_free_slots (free_slots)
    );

    inst_queue inst_queue_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_push       (push),
        .i_push_pc    (push_pc),
        .i_push_inst  (push_inst),
        .o_free_slots (free_slots),
        .o_not_empty  (not_empty),
        .o_head_pc    (head_pc),
        .o_head_inst  (head_inst),
        .i_pop        (pop)
    );

    inst_decoder inst_decoder_i (
        .*,
        .i_not_empty  (not_empty),
        .i_head_pc    (head_pc),
        .i_head_inst  (head_inst),
        .o_pop        (pop)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clk
);

    localparam realtime HALF_PERIOD = 20ns;

    initial begin
        o_clk = 1'b0;
    end

    always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- verif/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb import decode_pkg::*; ();

    localparam int N_LINES = 28;
    localparam int N_COLS = 15;
    localparam int RESET_CYCLES = 5;
    localparam int WDOG_CYCLES = 40 * N_LINES + RESET_CYCLES;
    // addi x0,x0,0 past the end of the list
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    logic                 clk;
    logic                 rst_n = 1'b0;
    logic                 wb_ack = 1'b0;
    logic [XLEN_INST-1:0] wb_dat = '0;
    logic                 dec_ready = 1'b0;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic [PC_W-1:0]      wb_adr;
    logic                 dec_valid;
    logic [PC_W-1:0]      dec_pc;
    logic                 dec_unknown;
    logic [1:0]           dec_disp_q;
    logic [1:0]           dec_issue_q;
    logic [3:0]           dec_micro_op;
    logic                 dec_rd_wen;
    logic [REG_IDX_W-1:0] dec_rd;
    logic [REG_IDX_W-1:0] dec_rs1;
    logic [REG_IDX_W-1:0] dec_rs2;
    logic [IMM_W-1:0]     dec_imm;
    logic                 dec_use_imm;
    logic                 dec_is_mv;
    logic                 dec_serialize;
    logic                 dec_is_store;

    logic [31:0] stim [N_LINES * N_COLS];
    logic [15:0] lfsr = 16'd40828;
    logic [1:0]  wait_left = '0;
    int          lines_done = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          grp_errs [7];

    tb_clock tb_clock_i (.o_clk(clk));

    decode_top decode_top_i (
        .i_clk(clk), .i_rst_n(rst_n),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
        .i_wb_ack(wb_ack), .i_wb_dat(wb_dat),
        .i_dec_ready(dec_ready), .o_dec_valid(dec_valid), .o_pc(dec_pc),
        .o_unknown(dec_unknown), .o_disp_q(dec_disp_q), .o_issue_q(dec_issue_q),
        .o_micro_op(dec_micro_op), .o_rd_wen(dec_rd_wen), .o_rd_idx(dec_rd),
        .o_rs1_idx(dec_rs1), .o_rs2_idx(dec_rs2), .o_imm(dec_imm),
        .o_use_imm(dec_use_imm), .o_is_mv(dec_is_mv),
        .o_serialize(dec_serialize), .o_is_store(dec_is_store)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [1:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] word_at(input logic [PC_W-1:0] adr);
        int idx;
        idx = int'(adr >> 2);
        if (idx < N_LINES) begin
            return stim[idx * N_COLS + 1];
        end
        return NOP_WORD;
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1: return "alu ops";
            2: return "control flow";
            3: return "memory ops";
            4: return "muldiv and system";
            5: return "dropped encodings";
            default: return "order";
        endcase
    endfunction

    task automatic check_field(input int line, input int grp, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) begin
            n_pass++;
        end else begin
            $display("** Error at %0d ns: line %0d field %s is 0x%0h, expected 0x%0h",
                     $time, line, name, got, exp);
            n_fail++;
            grp_errs[grp]++;
        end
    endtask

    task automatic check_line(input int idx);
        int base;
        int grp;
        base = idx * N_COLS;
        grp = int'(stim[base]);
        check_field(idx, 6, "pc", dec_pc, 32'(idx * 4));
        check_field(idx, grp, "unknown", 32'(dec_unknown), stim[base + 2]);
        check_field(idx, grp, "disp_q", 32'(dec_disp_q), stim[base + 3]);
        check_field(idx, grp, "issue_q", 32'(dec_issue_q), stim[base + 4]);
        check_field(idx, grp, "micro_op", 32'(dec_micro_op), stim[base + 5]);
        check_field(idx, grp, "rd_wen", 32'(dec_rd_wen), stim[base + 6]);
        check_field(idx, grp, "rd", 32'(dec_rd), stim[base + 7]);
        check_field(idx, grp, "rs1", 32'(dec_rs1), stim[base + 8]);
        check_field(idx, grp, "rs2", 32'(dec_rs2), stim[base + 9]);
        check_field(idx, grp, "imm", 32'(dec_imm), stim[base + 10]);
        check_field(idx, grp, "use_imm", 32'(dec_use_imm), stim[base + 11]);
        check_field(idx, grp, "is_mv", 32'(dec_is_mv), stim[base + 12]);
        check_field(idx, grp, "serialize", 32'(dec_serialize), stim[base + 13]);
        check_field(idx, grp, "is_store", 32'(dec_is_store), stim[base + 14]);
        if (idx == N_LINES - 1 || int'(stim[base + N_COLS]) != grp) begin
            $display("group %0d (%s) finished with %0d errors",
                     grp, group_name(grp), grp_errs[grp]);
        end
    endtask

    // wishbone slave memory and decode sink
    always @(posedge clk) begin : bus_and_sink
        logic [1:0] r;
        if (!rst_n) begin
            wb_ack <= 1'b0;
            dec_ready <= 1'b0;
        end else begin
            draw_bits(2, r);
            dec_ready <= (r != 2'd0);
            if (wb_ack) begin
                wb_ack <= 1'b0;
                draw_bits(2, r);
                wait_left <= r;
            end else if (wb_cyc && wb_stb) begin
                if (wait_left == 2'd0) begin
                    wb_ack <= 1'b1;
                    wb_dat <= word_at(wb_adr);
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && dec_valid && dec_ready) begin
            if (lines_done < N_LINES) begin
                check_line(lines_done);
            end
            lines_done = lines_done + 1;
        end
    end

    initial begin : main
        $readmemh("verif/decode_stim.txt", stim);
        repeat (RESET_CYCLES) @(posedge clk);
        check_field(-1, 6, "wb_cyc in reset", 32'(wb_cyc), 32'd0);
        check_field(-1, 6, "wb_stb in reset", 32'(wb_stb), 32'd0);
        check_field(-1, 6, "dec_valid in reset", 32'(dec_valid), 32'd0);
        rst_n <= 1'b1;
        @(posedge clk);
        check_field(-1, 6, "wb_cyc after reset", 32'(wb_cyc), 32'd0);
        check_field(-1, 6, "wb_stb after reset", 32'(wb_stb), 32'd0);
        check_field(-1, 6, "dec_valid after reset", 32'(dec_valid), 32'd0);
        wait (lines_done >= N_LINES);
        $display("group 6 (%s) finished with %0d errors", group_name(6), grp_errs[6]);
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the decoder stopped producing output after %0d of %0d words",
                 lines_done, N_LINES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/decode_stim.txt
// group inst unknown disp issue uop rd_wen rd rs1 rs2 imm use_imm is_mv serialize is_store
// all hex, word n is fetched from address 4n
1 002081B3 0 0 0 0 1 03 01 02 00000 0 0 0 0
1 407302BB 0 0 0 3 1 05 06 07 00000 0 0 0 0
1 02149413 0 0 0 4 1 08 09 00 00021 1 0 0 0
1 FFF5C513 0 0 0 A 1 0A 0B 00 FFFFF 1 0 0 0
1 0056B613 0 0 0 E 1 0C 0D 00 00005 1 0 0 0
1 12345737 0 0 0 F 1 0E 00 00 12345 1 0 0 0
1 00208033 0 0 0 0 0 00 01 02 00000 0 0 0 0
1 00080793 0 0 0 0 1 0F 10 00 00000 0 1 0 0
1 000908B3 0 0 0 0 1 11 12 00 00000 0 1 0 0
2 00208863 0 0 1 4 0 00 01 02 00010 1 0 0 0
2 FE41ECE3 0 0 1 8 0 00 03 04 FFFF8 1 0 0 0
2 001000EF 0 0 1 2 1 01 00 00 00400 1 0 0 0
2 00C302E7 0 0 1 3 1 05 06 00 0000C 1 0 0 0
2 FFFFF397 0 0 1 1 1 07 00 00 FFFFF 1 0 0 0
3 0104B403 0 1 0 0 1 08 09 00 00010 0 0 0 0
3 FFC5C503 0 1 0 0 1 0A 0B 00 FFFFC 0 0 0 0
3 00C6A423 0 1 0 0 0 00 0D 0C 00008 0 0 0 1
3 FEE7B823 0 1 0 0 0 00 0F 0E FFFF0 0 0 0 1
4 023130B3 0 0 2 4 1 01 02 03 00000 0 0 0 0
4 0262E23B 0 0 2 C 1 04 05 06 00000 0 0 0 0
4 300413F3 0 0 3 4 1 07 08 00 06008 1 0 1 0
4 3412E4F3 0 0 3 8 1 09 00 00 06825 1 0 1 0
4 00000073 0 0 3 2 0 00 00 00 00000 0 0 1 0
4 30200073 0 0 3 1 0 00 00 00 00000 0 0 1 0
5 003100D3 1 2 0 0 0 00 00 00 00000 0 0 0 0
5 003120AF 1 2 0 0 0 00 00 00 00000 0 0 0 0
5 00850085 1 2 0 0 0 00 00 00 00000 0 0 0 0
5 0FF0000F 1 2 0 0 0 00 00 00 00000 0 0 0 0

//--- files.f
src/decode_pkg.sv
src/inst_fetch.sv
src/inst_queue.sv
src/inst_decoder.sv
src/decode_top.sv
verif/tb_clock.sv
verif/decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= decode_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
